//--- game_display.f
hdl/game_pkg.sv
hdl/vga_timing.sv
hdl/timing_delay.sv
hdl/draw_background.sv
hdl/hp_control.sv
hdl/game_display.sv
test/tb_game_display.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= game_display.f
TOP       ?= tb_game_display
RTL_TOP   ?= game_display
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RTL_SRCS  ?= hdl/game_pkg.sv hdl/vga_timing.sv hdl/timing_delay.sv \
             hdl/draw_background.sv hdl/hp_control.sv hdl/game_display.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/tb_game_display.sv
`timescale 1ns/1ps

module tb_game_display
  import game_pkg::*;
();

  localparam int H_ACTIVE      = 64;
  localparam int H_FP          = 4;
  localparam int H_SYNC        = 8;
  localparam int H_BP          = 4;
  localparam int V_ACTIVE      = 48;
  localparam int V_FP          = 2;
  localparam int V_SYNC        = 3;
  localparam int V_BP          = 3;
  localparam int TOP_V_LINE    = 8;
  localparam int BOTTOM_V_LINE = 40;
  localparam int LEFT_H_LINE   = 10;
  localparam int RIGHT_H_LINE  = 50;
  localparam int BORDER        = 2;
  localparam int HP_MAX        = 4;
  localparam int BAR_LEFT      = 2;
  localparam int BAR_TOP       = 2;
  localparam int BAR_HEIGHT    = 3;
  localparam int BAR_STEP      = 3;
  localparam int H_TOTAL       = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL       = V_ACTIVE + V_FP + V_SYNC + V_BP;
  localparam int PIPE_DEPTH    = 3;
  localparam int TEST_FRAMES   = 8;
  localparam int CLK_PERIOD    = 20;

  typedef struct packed {
    int   h;
    int   v;
    logic hs;
    logic vs;
    rgb_t rgb;
  } pix_t;

  logic        pclk;
  logic        rst_n;
  logic        game_button;
  logic        menu_button;
  logic        player_hit;
  logic        hsync;
  logic        vsync;
  logic [3:0]  r;
  logic [3:0]  g;
  logic [3:0]  b;
  logic        game_over;
  int          tb_h;
  int          tb_v;
  game_state_t model_state;
  int          model_hp;
  logic        go_allowed;
  logic [31:0] lfsr_state = 32'hce77;
  pix_t        exp_q[$];
  int          errors = 0;
  int          checks = 0;

  game_display #(
    .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
    .TOP_V_LINE(TOP_V_LINE), .BOTTOM_V_LINE(BOTTOM_V_LINE),
    .LEFT_H_LINE(LEFT_H_LINE), .RIGHT_H_LINE(RIGHT_H_LINE), .BORDER(BORDER),
    .HP_MAX(HP_MAX), .BAR_LEFT(BAR_LEFT), .BAR_TOP(BAR_TOP),
    .BAR_HEIGHT(BAR_HEIGHT), .BAR_STEP(BAR_STEP)
  ) i_game_display (
    .pclk(pclk), .rst_n(rst_n), .game_button(game_button),
    .menu_button(menu_button), .player_hit(player_hit),
    .hsync(hsync), .vsync(vsync), .r(r), .g(g), .b(b), .game_over(game_over)
  );

  always #(CLK_PERIOD / 2) pclk = ~pclk;

  // own copy of the raster position, same as the DUT counters
  always @(posedge pclk) begin
    if (!rst_n) begin
      tb_h <= 0;
      tb_v <= 0;
    end else if (tb_h == H_TOTAL - 1) begin
      tb_h <= 0;
      tb_v <= (tb_v == V_TOTAL - 1) ? 0 : tb_v + 1;
    end else begin
      tb_h <= tb_h + 1;
    end
  end

  function automatic rgb_t ref_pixel(int h, int v, game_state_t st, int hp);
    logic in_rect;
    logic in_band;
    rgb_t colour;
    in_rect = v >= TOP_V_LINE && v <= BOTTOM_V_LINE && h >= LEFT_H_LINE && h <= RIGHT_H_LINE;
    in_band = v < TOP_V_LINE + BORDER || v > BOTTOM_V_LINE - BORDER ||
              h < LEFT_H_LINE + BORDER || h > RIGHT_H_LINE - BORDER;
    if (h >= H_ACTIVE || v >= V_ACTIVE) begin
      colour = '0;
    end else if (v >= BAR_TOP && v < BAR_TOP + BAR_HEIGHT &&
                 h >= BAR_LEFT && h < BAR_LEFT + hp * BAR_STEP) begin
      colour = bar_colour;
    end else if (in_rect) begin
      colour = in_band ? border_colour : field_colour;
    end else if (st == st_game) begin
      colour = game_colour;
    end else if (st == st_over) begin
      colour = over_colour;
    end else begin
      colour = menu_colour;
    end
    return colour;
  endfunction

  // expected pixels wait out the three pipeline stages
  always @(negedge pclk) begin
    pix_t want;
    if (rst_n) begin
      want.h   = tb_h;
      want.v   = tb_v;
      want.hs  = tb_h >= H_ACTIVE + H_FP && tb_h < H_ACTIVE + H_FP + H_SYNC;
      want.vs  = tb_v >= V_ACTIVE + V_FP && tb_v < V_ACTIVE + V_FP + V_SYNC;
      want.rgb = ref_pixel(tb_h, tb_v, model_state, model_hp);
      exp_q.push_back(want);
      if (exp_q.size() > PIPE_DEPTH) begin
        want = exp_q.pop_front();
        checks++;
        if ({r, g, b} !== want.rgb) begin
          errors++;
          $display("Error at %0t: pixel (%0d,%0d) rgb %h, expected %h",
                   $time, want.h, want.v, {r, g, b}, want.rgb);
        end
        if (hsync !== want.hs || vsync !== want.vs) begin
          errors++;
          $display("Error at %0t: pixel (%0d,%0d) syncs %b%b, expected %b%b",
                   $time, want.h, want.v, hsync, vsync, want.hs, want.vs);
        end
      end
      if (game_over !== 1'b0 && !go_allowed) begin
        errors++;
        $display("Error at %0t: game_over is %b outside the end of a game", $time, game_over);
      end
    end
  end

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    // taps 32 22 2 1
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = (val << 1) | int'(lfsr_state[0]);
    end
  endtask

  task automatic step_cycle();
    @(posedge pclk);
    #2;
  endtask

  // returns early in vertical blanking, so model changes never meet a visible pixel
  task automatic wait_vblank();
    step_cycle();
    while (!(tb_v == V_ACTIVE + 1 && tb_h == 0)) begin
      step_cycle();
    end
  endtask

  task automatic pulse_button(input bit menu);
    if (menu) begin
      menu_button = 1'b1;
    end else begin
      game_button = 1'b1;
    end
    step_cycle();
    menu_button = 1'b0;
    game_button = 1'b0;
  endtask

  task automatic apply_hit();
    int gap;
    int hold;
    int n;
    take_bits(6, gap);
    take_bits(3, hold);
    repeat (gap) step_cycle();
    player_hit = 1'b1;
    model_hp = model_hp - 1;
    if (model_hp == 0) begin
      go_allowed = 1'b1;
      n = 0;
      while (!game_over && n < 16) begin
        step_cycle();
        n++;
      end
      if (!game_over) begin
        errors++;
        $display("game_over never rose after the last hit");
      end
      n = 0;
      while (game_over && n < 16) begin
        step_cycle();
        n++;
      end
      if (game_over) begin
        errors++;
        $display("game_over stayed high after the game ended");
      end
      // leaving st_game reloads hp
      model_state = st_over;
      model_hp = HP_MAX;
      go_allowed = 1'b0;
    end
    // held level, one edge only
    repeat (hold + 2) step_cycle();
    player_hit = 1'b0;
    step_cycle();
  endtask

  initial begin
    pclk = 1'b0;
    rst_n = 1'b0;
    game_button = 1'b0;
    menu_button = 1'b0;
    player_hit = 1'b0;
    model_state = st_menu;
    model_hp = HP_MAX;
    go_allowed = 1'b0;
    repeat (2) @(posedge pclk);
    #2;
    rst_n = 1'b1;

    wait_vblank();
    wait_vblank();
    pulse_button(1'b0);
    model_state = st_game;
    for (int i = 0; i < HP_MAX; i++) begin
      wait_vblank();
      apply_hit();
    end
    wait_vblank();
    pulse_button(1'b1);
    model_state = st_menu;
    wait_vblank();

    $display("pixel checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #((TEST_FRAMES + 2) * H_TOTAL * V_TOTAL * CLK_PERIOD);
    $display("watchdog expired before the test sequence finished");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- hdl/game_display.sv
`timescale 1ns/1ps

module game_display
  import game_pkg::*;
#(
  parameter int H_ACTIVE      = 1024,
  parameter int H_FP          = 24,
  parameter int H_SYNC        = 136,
  parameter int H_BP          = 160,
  parameter int V_ACTIVE      = 768,
  parameter int V_FP          = 3,
  parameter int V_SYNC        = 6,
  parameter int V_BP          = 29,
  parameter int TOP_V_LINE    = 317,
  parameter int BOTTOM_V_LINE = 617,
  parameter int LEFT_H_LINE   = 361,
  parameter int RIGHT_H_LINE  = 661,
  parameter int BORDER        = 7,
  parameter int HP_MAX        = 5,
  parameter int BAR_LEFT      = 40,
  parameter int BAR_TOP       = 20,
  parameter int BAR_HEIGHT    = 16,
  parameter int BAR_STEP      = 24
) (
  input  logic       pclk,
  input  logic       rst_n,
  input  logic       game_button,
  input  logic       menu_button,
  input  logic       player_hit,
  output logic       hsync,
  output logic       vsync,
  output logic [3:0] r,
  output logic [3:0] g,
  output logic [3:0] b,
  output logic       game_over
);

  // two counters plus four strobes
  localparam int RASTER_W = 2 * $bits(coord_t) + 4;
  localparam int CLK_DEL  = 2;

  coord_t hcount_tim, vcount_tim;
  logic   hsync_tim, vsync_tim, hblnk_tim, vblnk_tim;
  coord_t hcount_del, vcount_del;
  logic   hsync_del, vsync_del, hblnk_del, vblnk_del;
  rgb_t   rgb_bg;
  rgb_t   rgb_final;
  logic   game_on;

  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
  ) i_vga_timing (
    .pclk(pclk), .rst_n(rst_n),
    .hcount(hcount_tim), .vcount(vcount_tim),
    .hsync(hsync_tim), .vsync(vsync_tim),
    .hblnk(hblnk_tim), .vblnk(vblnk_tim)
  );

  // raster held back to meet the background colour
  timing_delay #(.WIDTH(RASTER_W), .CLK_DEL(CLK_DEL)) i_timing_delay (
    .pclk(pclk), .rst_n(rst_n),
    .din({hcount_tim, vcount_tim, hsync_tim, vsync_tim, hblnk_tim, vblnk_tim}),
    .dout({hcount_del, vcount_del, hsync_del, vsync_del, hblnk_del, vblnk_del})
  );

  draw_background #(
    .TOP_V_LINE(TOP_V_LINE), .BOTTOM_V_LINE(BOTTOM_V_LINE),
    .LEFT_H_LINE(LEFT_H_LINE), .RIGHT_H_LINE(RIGHT_H_LINE),
    .BORDER(BORDER)
  ) i_draw_background (
    .pclk(pclk), .rst_n(rst_n),
    .hcount(hcount_tim), .vcount(vcount_tim),
    .hblnk(hblnk_tim), .vblnk(vblnk_tim),
    .game_button(game_button), .menu_button(menu_button),
    .game_over(game_over),
    .rgb(rgb_bg), .game_on(game_on)
  );

  hp_control #(
    .HP_MAX(HP_MAX), .BAR_LEFT(BAR_LEFT), .BAR_TOP(BAR_TOP),
    .BAR_HEIGHT(BAR_HEIGHT), .BAR_STEP(BAR_STEP)
  ) i_hp_control (
    .pclk(pclk), .rst_n(rst_n),
    .hcount(hcount_del), .vcount(vcount_del),
    .hsync(hsync_del), .vsync(vsync_del),
    .hblnk(hblnk_del), .vblnk(vblnk_del),
    .rgb_in(rgb_bg), .game_on(game_on), .player_hit(player_hit),
    .hsync_out(hsync), .vsync_out(vsync),
    .rgb_out(rgb_final), .game_over(game_over)
  );

  assign {r, g, b} = rgb_final;

endmodule

//--- hdl/hp_control.sv
`timescale 1ns/1ps

module hp_control
  import game_pkg::*;
#(
  parameter int HP_MAX     = 5,
  parameter int BAR_LEFT   = 40,
  parameter int BAR_TOP    = 20,
  parameter int BAR_HEIGHT = 16,
  parameter int BAR_STEP   = 24
) (
  input  logic   pclk,
  input  logic   rst_n,
  input  coord_t hcount,
  input  coord_t vcount,
  input  logic   hsync,
  input  logic   vsync,
  input  logic   hblnk,
  input  logic   vblnk,
  input  rgb_t   rgb_in,
  input  logic   game_on,
  input  logic   player_hit,
  output logic   hsync_out,
  output logic   vsync_out,
  output rgb_t   rgb_out,
  output logic   game_over
);

  hp_t    hp;
  logic   hit_q;
  logic   hit_rise;
  coord_t bar_right;
  logic   in_bar;

  // level in, one strobe per rising edge
  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      hit_q <= 1'b0;
    end else begin
      hit_q <= player_hit;
    end
  end

  assign hit_rise = player_hit && !hit_q;

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      hp <= hp_t'(HP_MAX);
    end else if (!game_on) begin
      hp <= hp_t'(HP_MAX);
    end else if (hit_rise && hp != '0) begin
      hp <= hp - 1'b1;
    end
  end

  // held until the game leaves the play state
  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      game_over <= 1'b0;
    end else begin
      game_over <= game_on && (hp == '0 || game_over);
    end
  end

  // bar length follows remaining hp
  assign bar_right = coord_t'(BAR_LEFT) + coord_t'(hp) * coord_t'(BAR_STEP);

  assign in_bar = !(hblnk || vblnk) &&
                  (vcount >= BAR_TOP) && (vcount < BAR_TOP + BAR_HEIGHT) &&
                  (hcount >= BAR_LEFT) && (hcount < bar_right);

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      hsync_out <= 1'b0;
      vsync_out <= 1'b0;
      rgb_out   <= '0;
    end else begin
      hsync_out <= hsync;
      vsync_out <= vsync;
      rgb_out   <= in_bar ? bar_colour : rgb_in;
    end
  end

  hp_bounded: assert property (
    @(posedge pclk) disable iff (!rst_n)
    hp <= HP_MAX
  ) else $error("hp %0d above HP_MAX", hp);

endmodule

//--- hdl/draw_background.sv
`timescale 1ns/1ps

module draw_background
  import game_pkg::*;
#(
  parameter int TOP_V_LINE    = 317,
  parameter int BOTTOM_V_LINE = 617,
  parameter int LEFT_H_LINE   = 361,
  parameter int RIGHT_H_LINE  = 661,
  parameter int BORDER        = 7
) (
  input  logic   pclk,
  input  logic   rst_n,
  input  coord_t hcount,
  input  coord_t vcount,
  input  logic   hblnk,
  input  logic   vblnk,
  input  logic   game_button,
  input  logic   menu_button,
  input  logic   game_over,
  output rgb_t   rgb,
  output logic   game_on
);

  game_state_t state;
  game_state_t state_nxt;

  logic inside_c;
  logic border_c;
  logic blank_q;
  logic inside_q;
  logic border_q;
  rgb_t fill_colour;

  // game over wins, then menu, then start
  always_comb begin
    state_nxt = state;
    if (state == st_game && game_over) begin
      state_nxt = st_over;
    end else if (menu_button) begin
      state_nxt = st_menu;
    end else if (state == st_menu && game_button) begin
      state_nxt = st_game;
    end
  end

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      state <= st_menu;
    end else begin
      state <= state_nxt;
    end
  end

  assign game_on = (state == st_game);

  // rectangle bounds are inclusive
  assign inside_c = (vcount >= TOP_V_LINE) && (vcount <= BOTTOM_V_LINE) &&
                    (hcount >= LEFT_H_LINE) && (hcount <= RIGHT_H_LINE);

  assign border_c = inside_c &&
                    ((vcount < TOP_V_LINE + BORDER) ||
                     (vcount > BOTTOM_V_LINE - BORDER) ||
                     (hcount < LEFT_H_LINE + BORDER) ||
                     (hcount > RIGHT_H_LINE - BORDER));

  // stage one, region decode
  always_ff @(posedge pclk) begin
    blank_q  <= hblnk || vblnk;
    inside_q <= inside_c;
    border_q <= border_c;
  end

  always_comb begin
    case (state)
      st_game: fill_colour = game_colour;
      st_over: fill_colour = over_colour;
      default: fill_colour = menu_colour;
    endcase
  end

  // stage two, colour select
  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      rgb <= '0;
    end else if (blank_q) begin
      rgb <= '0;
    end else if (border_q) begin
      rgb <= border_colour;
    end else if (inside_q) begin
      rgb <= field_colour;
    end else begin
      rgb <= fill_colour;
    end
  end

  state_legal: assert property (
    @(posedge pclk) disable iff (!rst_n)
    state inside {st_menu, st_game, st_over}
  ) else $error("illegal game state %0d", state);

endmodule

//--- hdl/timing_delay.sv
`timescale 1ns/1ps

module timing_delay #(
  parameter int WIDTH   = 28,
  parameter int CLK_DEL = 2
) (
  input  logic             pclk,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  logic [WIDTH-1:0] stage [CLK_DEL];

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      for (int i = 0; i < CLK_DEL; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= din;
      for (int i = 1; i < CLK_DEL; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign dout = stage[CLK_DEL-1];

  // a zero-length chain would leave the consumer one cycle out of step
  del_nonzero: assert property (
    @(posedge pclk) CLK_DEL >= 1
  ) else $error("timing_delay needs CLK_DEL of at least 1");

endmodule

//--- hdl/vga_timing.sv
`timescale 1ns/1ps

module vga_timing
  import game_pkg::*;
#(
  parameter int H_ACTIVE = 1024,
  parameter int H_FP     = 24,
  parameter int H_SYNC   = 136,
  parameter int H_BP     = 160,
  parameter int V_ACTIVE = 768,
  parameter int V_FP     = 3,
  parameter int V_SYNC   = 6,
  parameter int V_BP     = 29
) (
  input  logic   pclk,
  input  logic   rst_n,
  output coord_t hcount,
  output coord_t vcount,
  output logic   hsync,
  output logic   vsync,
  output logic   hblnk,
  output logic   vblnk
);

  localparam int H_TOTAL      = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL      = V_ACTIVE + V_FP + V_SYNC + V_BP;
  localparam int H_SYNC_START = H_ACTIVE + H_FP;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
  localparam int V_SYNC_START = V_ACTIVE + V_FP;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

  coord_t hcount_nxt;
  coord_t vcount_nxt;

  // next raster position, vertical steps at end of line
  always_comb begin
    hcount_nxt = hcount + 1'b1;
    vcount_nxt = vcount;
    if (hcount == coord_t'(H_TOTAL - 1)) begin
      hcount_nxt = '0;
      if (vcount == coord_t'(V_TOTAL - 1)) begin
        vcount_nxt = '0;
      end else begin
        vcount_nxt = vcount + 1'b1;
      end
    end
  end

  // strobes decoded from the next position so they line up with the counters
  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      hcount <= '0;
      vcount <= '0;
      hsync  <= 1'b0;
      vsync  <= 1'b0;
      hblnk  <= 1'b0;
      vblnk  <= 1'b0;
    end else begin
      hcount <= hcount_nxt;
      vcount <= vcount_nxt;
      hsync  <= (hcount_nxt >= H_SYNC_START) && (hcount_nxt < H_SYNC_END);
      vsync  <= (vcount_nxt >= V_SYNC_START) && (vcount_nxt < V_SYNC_END);
      hblnk  <= (hcount_nxt >= H_ACTIVE);
      vblnk  <= (vcount_nxt >= V_ACTIVE);
    end
  end

  hcount_in_range: assert property (
    @(posedge pclk) disable iff (!rst_n)
    hcount < H_TOTAL
  ) else $error("hcount %0d past line length", hcount);

endmodule

//--- hdl/game_pkg.sv
package game_pkg;

  // pixel and line counters
  typedef logic [11:0] coord_t;

  // 4 bits per channel, red on top
  typedef logic [11:0] rgb_t;

  typedef logic [3:0] hp_t;

  typedef enum logic [1:0] {
    st_menu = 2'd0,
    st_game = 2'd1,
    st_over = 2'd2
  } game_state_t;

  // fill outside the play area, one per state
  localparam rgb_t menu_colour   = 12'h1_3_8;
  localparam rgb_t game_colour   = 12'h2_6_2;
  localparam rgb_t over_colour   = 12'h8_1_1;

  localparam rgb_t field_colour  = 12'hc_c_a;
  localparam rgb_t border_colour = 12'hf_f_f;
  localparam rgb_t bar_colour    = 12'hf_2_2;

endpackage
